//--- read_cache.f
+incdir+test
source/rcache_pkg.sv
source/line_store.sv
source/miss_fsm.sv
source/cache_csr.sv
source/read_cache.sv
test/read_cache_tb.sv

//--- Bender.yml
package:
  name: read_cache

sources:
  - source/rcache_pkg.sv
  - source/line_store.sv
  - source/miss_fsm.sv
  - source/cache_csr.sv
  - source/read_cache.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/read_cache_tb.sv

//--- test/read_cache_tests.svh
task automatic cold_miss_then_hit();
    check_read(32'h0000_1044, 1'b0);
    check_read(32'h0000_1044, 1'b1);
    check_word(word_t'(rsp_cycles), 32'd2, "hit latency in cycles");
endtask

task automatic word_offsets();
    int reqs_before;
    check_read(32'h0000_2080, 1'b0);
    reqs_before = mem_reqs;
    for (int i = LINE_WORDS - 1; i >= 0; i--) begin
        check_read(32'h0000_2080 + 4 * i, 1'b1);
    end
    check_word(word_t'(mem_reqs), word_t'(reqs_before), "memory requests during hits");
endtask

// Both addresses map to index 0xC.
task automatic conflict_eviction();
    for (int i = 0; i < 3; i++) begin
        check_read(32'h0000_30C4, 1'b0);
        check_read(32'h0000_51C8, 1'b0);
    end
endtask

task automatic check_counters();
    word_t value;
    csr_read(CSR_HITS, value);
    check_word(value, word_t'(exp_hits), "hit counter");
    csr_read(CSR_MISSES, value);
    check_word(value, word_t'(exp_misses), "miss counter");
endtask

task automatic hit_miss_counters();
    check_counters();
    check_read(32'h0000_0600, 1'b0);
    check_read(32'h0000_0600, 1'b1);
    check_read(32'h0000_0604, 1'b1);
    check_read(32'h0000_0714, 1'b0);
    check_counters();
    csr_write(CSR_HITS, '0);
    exp_hits = 0;
    check_counters();
    csr_write(CSR_MISSES, '0);
    exp_misses = 0;
    check_counters();
endtask

task automatic flush_and_disable();
    word_t value;
    check_read(32'h0000_0600, 1'b1);
    csr_write(CSR_CTRL, 32'h3);
    check_read(32'h0000_0600, 1'b0);
    csr_write(CSR_CTRL, 32'h0);
    csr_read(CSR_CTRL, value);
    check_word(value, 32'h0, "control register while disabled");
    // A valid line still misses while disabled.
    check_read(32'h0000_0600, 1'b0);
    // No fill while disabled, so the line stays cold.
    repeat (3) begin
        check_read(32'h0000_0A28, 1'b0);
    end
    csr_write(CSR_CTRL, 32'h1);
    check_read(32'h0000_0A28, 1'b0);
    check_read(32'h0000_0A28, 1'b1);
endtask

task automatic busy_ignores_read();
    int reqs_before;
    reqs_before = mem_reqs;
    addr = 32'h0000_0B30;
    read_en = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    // Second strobe lands in LOOKUP.
    check_hit(busy, 1'b1, "busy after accepted read");
    addr = 32'h0000_0C3C;
    @(posedge clk);
    #DRIVE_DELAY;
    read_en = 1'b0;
    wait_response();
    check_word(data_out, model_word(32'h0000_0B30), "read data");
    check_hit(hit, 1'b0, "hit flag");
    for (int i = 0; i < QUIET_CYCLES; i++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        check_hit(rsp_valid, 1'b0, "response to ignored read");
    end
    check_word(word_t'(mem_reqs - reqs_before), 32'd1, "memory requests");
endtask

//--- test/read_cache_tb.sv
`default_nettype none
`timescale 1ns/10ps

module read_cache_tb import rcache_pkg::*; ;

    localparam int CACHE_BYTES = 256;
    localparam int CLK_HALF = 4;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY = 1;
    localparam int RSP_TIMEOUT = 64;
    localparam int QUIET_CYCLES = 12;
    localparam word_t WORD_KEY = 32'h5A3C_96E1;

    logic      clk;
    logic      rst;
    logic      read_en;
    word_t     addr;
    word_t     data_out;
    logic      hit;
    logic      rsp_valid;
    logic      busy;
    logic      mem_req;
    word_t     mem_addr;
    line_t     mem_data;
    logic      mem_ready;
    logic      csr_we;
    csr_addr_t csr_addr;
    word_t     csr_wdata;
    word_t     csr_rdata;

    logic [31:0] lcg_state;
    int mem_reqs;
    int exp_hits;
    int exp_misses;
    int rsp_cycles;

    read_cache #(
        .CACHE_BYTES(CACHE_BYTES)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Each word holds its own byte address XOR a fixed key.
    function automatic word_t model_word(input word_t a);
        return {a[31:2], 2'b00} ^ WORD_KEY;
    endfunction

    function automatic line_t model_line(input word_t base);
        line_t line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i * 32 +: 32] = model_word(base + 4 * i);
        end
        return line;
    endfunction

    // Memory answers each request after 0 to 3 idle cycles.
    initial begin
        int delay;
        lcg_state = 32'd68640;
        mem_reqs = 0;
        mem_ready = 1'b0;
        mem_data = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            mem_ready = 1'b0;
            if (mem_req) begin
                mem_reqs++;
                delay = next_rand() % 4;
                repeat (delay) @(posedge clk);
                #DRIVE_DELAY;
                mem_data = model_line(mem_addr);
                mem_ready = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY;
                mem_ready = 1'b0;
            end
        end
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_hit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_response();
        rsp_cycles = 1;
        while (rsp_valid !== 1'b1) begin
            if (rsp_cycles >= RSP_TIMEOUT) begin
                $display("timeout: the cache gave no response within %0d cycles", RSP_TIMEOUT);
                abort_run();
            end
            @(posedge clk);
            #DRIVE_DELAY;
            rsp_cycles++;
        end
    endtask

    task automatic check_read(input word_t a, input logic exp_hit);
        addr = a;
        read_en = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        read_en = 1'b0;
        wait_response();
        check_word(data_out, model_word(a), "read data");
        check_hit(hit, exp_hit, "hit flag");
        if (exp_hit) begin
            exp_hits++;
        end else begin
            exp_misses++;
        end
        // Busy is still high in the response cycle.
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic csr_write(input csr_addr_t a, input word_t d);
        csr_addr = a;
        csr_wdata = d;
        csr_we = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        csr_we = 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t a, output word_t d);
        csr_addr = a;
        @(posedge clk);
        #DRIVE_DELAY;
        d = csr_rdata;
    endtask

    `include "read_cache_tests.svh"

    initial begin
        rst = 1'b0;
        read_en = 1'b0;
        addr = '0;
        csr_we = 1'b0;
        csr_addr = CSR_CTRL;
        csr_wdata = '0;
        exp_hits = 0;
        exp_misses = 0;
        rsp_cycles = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        cold_miss_then_hit();
        word_offsets();
        conflict_eviction();
        hit_miss_counters();
        flush_and_disable();
        busy_ignores_read();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/read_cache.sv
`default_nettype none
`timescale 1ns/10ps

module read_cache import rcache_pkg::*; #(
    parameter int CACHE_BYTES = 8192
) (
    input  logic      clk,
    input  logic      rst,

    // Processor read port.
    input  logic      read_en,
    input  word_t     addr,
    output word_t     data_out,
    output logic      hit,
    output logic      rsp_valid,
    output logic      busy,

    // Main memory.
    output logic      mem_req,
    output word_t     mem_addr,
    input  line_t     mem_data,
    input  logic      mem_ready,

    // Registers.
    input  logic      csr_we,
    input  csr_addr_t csr_addr,
    input  word_t     csr_wdata,
    output word_t     csr_rdata
);

    word_t req_addr;
    logic  lookup;
    logic  fill_en;
    logic  lookup_hit;
    word_t lookup_word;
    logic  cache_enable;
    logic  flush;
    logic  hit_evt;
    logic  miss_evt;

    line_store #(
        .CACHE_BYTES(CACHE_BYTES)
    ) u_store (
        .clk(clk),
        .rst(rst),
        .addr(req_addr),
        .lookup(lookup),
        .fill_en(fill_en),
        .mem_data(mem_data),
        .flush(flush),
        .lookup_hit(lookup_hit),
        .lookup_word(lookup_word)
    );

    miss_fsm u_fsm (
        .clk(clk),
        .rst(rst),
        .read_en(read_en),
        .addr(addr),
        .lookup_hit(lookup_hit),
        .lookup_word(lookup_word),
        .cache_enable(cache_enable),
        .mem_ready(mem_ready),
        .mem_data(mem_data),
        .req_addr(req_addr),
        .lookup(lookup),
        .fill_en(fill_en),
        .mem_req(mem_req),
        .mem_addr(mem_addr),
        .data_out(data_out),
        .hit(hit),
        .rsp_valid(rsp_valid),
        .busy(busy),
        .hit_evt(hit_evt),
        .miss_evt(miss_evt)
    );

    cache_csr u_csr (
        .clk(clk),
        .rst(rst),
        .csr_we(csr_we),
        .csr_addr(csr_addr),
        .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata),
        .hit_evt(hit_evt),
        .miss_evt(miss_evt),
        .cache_enable(cache_enable),
        .flush(flush)
    );

endmodule

`default_nettype wire

//--- source/cache_csr.sv
`default_nettype none
`timescale 1ns/10ps

module cache_csr import rcache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      csr_we,
    input  csr_addr_t csr_addr,
    input  word_t     csr_wdata,
    output word_t     csr_rdata,
    input  logic      hit_evt,
    input  logic      miss_evt,
    output logic      cache_enable,
    output logic      flush
);

    localparam int NUM_COUNTERS = 2;

    logic ctrl_we;
    logic [NUM_COUNTERS-1:0] cnt_evt;
    logic [NUM_COUNTERS-1:0] cnt_clr;
    word_t counters [NUM_COUNTERS];

    assign ctrl_we = csr_we && (csr_addr == CSR_CTRL);

    // Flush bit reads back as zero; it only fires the strobe.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cache_enable <= 1'b1;
            flush <= 1'b0;
        end else begin
            flush <= ctrl_we && csr_wdata[CTRL_FLUSH_BIT];
            if (ctrl_we) begin
                cache_enable <= csr_wdata[CTRL_ENABLE_BIT];
            end
        end
    end

    // Index 0 counts hits, index 1 counts misses.
    assign cnt_evt = {miss_evt, hit_evt};
    assign cnt_clr[0] = csr_we && (csr_addr == CSR_HITS);
    assign cnt_clr[1] = csr_we && (csr_addr == CSR_MISSES);

    // A clear in the same cycle as an event wins.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                counters[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                if (cnt_clr[i]) begin
                    counters[i] <= '0;
                end else if (cnt_evt[i]) begin
                    counters[i] <= counters[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (csr_addr)
            CSR_CTRL: csr_rdata = word_t'(cache_enable) << CTRL_ENABLE_BIT;
            CSR_HITS: csr_rdata = counters[0];
            CSR_MISSES: csr_rdata = counters[1];
            default: csr_rdata = '0;
        endcase
    end

    // One response per request, so never both at once.
    a_single_event: assert property (
        @(posedge clk) disable iff (!rst)
        !(hit_evt && miss_evt)
    );

endmodule

`default_nettype wire

//--- source/miss_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module miss_fsm import rcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  read_en,
    input  word_t addr,
    input  logic  lookup_hit,
    input  word_t lookup_word,
    input  logic  cache_enable,
    input  logic  mem_ready,
    input  line_t mem_data,
    output word_t req_addr,
    output logic  lookup,
    output logic  fill_en,
    output logic  mem_req,
    output word_t mem_addr,
    output word_t data_out,
    output logic  hit,
    output logic  rsp_valid,
    output logic  busy,
    output logic  hit_evt,
    output logic  miss_evt
);

    localparam int LINE_LSB = OFFSET_BITS + BYTE_BITS;

    fsm_state_t state;
    logic accept;
    logic take_hit;
    logic line_done;

    // Busy also covers the response cycle.
    assign busy = (state != IDLE) || rsp_valid;
    assign accept = read_en && !busy;

    assign lookup = (state == LOOKUP);
    assign take_hit = lookup && lookup_hit && cache_enable;
    assign line_done = (state == FETCH) && mem_ready;

    // Disabled cache reads straight from memory and leaves the store alone.
    assign fill_en = line_done && cache_enable;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
            mem_req <= 1'b0;
            rsp_valid <= 1'b0;
            hit <= 1'b0;
            hit_evt <= 1'b0;
            miss_evt <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            hit_evt <= 1'b0;
            miss_evt <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (take_hit) begin
                        state <= IDLE;
                        rsp_valid <= 1'b1;
                        hit <= 1'b1;
                        hit_evt <= 1'b1;
                    end else begin
                        state <= FETCH;
                        mem_req <= 1'b1;
                    end
                end
                FETCH: begin
                    if (mem_ready) begin
                        state <= FILL;
                        mem_req <= 1'b0;
                    end
                end
                FILL: begin
                    state <= IDLE;
                    rsp_valid <= 1'b1;
                    hit <= 1'b0;
                    miss_evt <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= addr;
        end
        if (lookup && !take_hit) begin
            mem_addr <= {req_addr[WORD_BITS-1:LINE_LSB], {LINE_LSB{1'b0}}};
        end
        // Miss word comes from the bus, not from a second store read.
        if (take_hit) begin
            data_out <= lookup_word;
        end else if (line_done) begin
            data_out <= line_word(mem_data, req_addr[BYTE_BITS +: OFFSET_BITS]);
        end
    end

    a_req_falls_after_ready: assert property (
        @(posedge clk) disable iff (!rst)
        $fell(mem_req) |-> $past(mem_ready)
    );

endmodule

`default_nettype wire

//--- source/line_store.sv
`default_nettype none
`timescale 1ns/10ps

module line_store import rcache_pkg::*; #(
    parameter int CACHE_BYTES = 8192
) (
    input  logic  clk,
    input  logic  rst,
    input  word_t addr,
    input  logic  lookup,
    input  logic  fill_en,
    input  line_t mem_data,
    input  logic  flush,
    output logic  lookup_hit,
    output word_t lookup_word
);

    localparam int IDX_W = index_bits(CACHE_BYTES);
    localparam int TAG_W = WORD_BITS - IDX_W - OFFSET_BITS - BYTE_BITS;
    localparam int LINES = 2 ** IDX_W;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [IDX_W-1:0] index_t;

    tag_t    tag;
    index_t  index;
    offset_t offset;

    tag_t  tag_mem [LINES];
    line_t data_mem [LINES];
    logic [LINES-1:0] valid;

    // Byte offset bits are dropped, only whole words are read.
    assign tag = addr[WORD_BITS-1 -: TAG_W];
    assign index = addr[OFFSET_BITS + BYTE_BITS +: IDX_W];
    assign offset = addr[BYTE_BITS +: OFFSET_BITS];

    // Flush wins over a fill to the same cycle.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index] <= tag;
            data_mem[index] <= mem_data;
        end
    end

    assign lookup_hit = lookup && valid[index] && (tag_mem[index] == tag);

    // Word select runs whether or not the line is valid.
    assign lookup_word = line_word(data_mem[index], offset);

    // The controller never fills while the register block flushes.
    a_no_fill_on_flush: assert property (
        @(posedge clk) disable iff (!rst)
        !(fill_en && flush)
    );

endmodule

`default_nettype wire

//--- source/rcache_pkg.sv
`default_nettype none

package rcache_pkg;

    localparam int WORD_BITS = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_BITS = LINE_WORDS * WORD_BITS;
    localparam int OFFSET_BITS = 2;
    localparam int BYTE_BITS = 2;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;

    // Register map.
    typedef logic [1:0] csr_addr_t;

    localparam csr_addr_t CSR_CTRL = 2'd0;
    localparam csr_addr_t CSR_HITS = 2'd1;
    localparam csr_addr_t CSR_MISSES = 2'd2;

    // Bit positions in CSR_CTRL.
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_FLUSH_BIT = 1;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FETCH,
        FILL
    } fsm_state_t;

    // Index width for a cache of the given size in bytes, 16 bytes per line.
    function automatic int index_bits(input int cache_bytes);
        return $clog2(cache_bytes / 16);
    endfunction

    // Word at a given offset within a line.
    function automatic word_t line_word(input line_t line, input offset_t offset);
        return line[offset * WORD_BITS +: WORD_BITS];
    endfunction

endpackage

`default_nettype wire
